// ==== hw/snd_consts.svh ====
`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

// Data path widths
`define SND_CHAN_W 8
`define SND_MIX_W 12
`define SND_PCM_W 16

// Soundrive (covox) channel ports, all odd
`define SND_PORT_A 8'h0F
`define SND_PORT_B 8'h1F
`define SND_PORT_C 8'h4F
`define SND_PORT_D 8'h5F

// Port #FE bit that drives the speaker
`define SND_BEEPER_BIT 4

// Beeper weight in the mix
`define SND_BEEP_LEVEL 256

// Above this mix level the output slope is halved
`define SND_KNEE 1024

// fclk cycles per audio sample
`define SND_SAMPLE_DIV 8

`endif

// ==== hw/snd_pkg.sv ====
`include "snd_consts.svh"

package snd_pkg;

  // One Soundrive channel, also the width of the I/O data bus
  typedef logic [`SND_CHAN_W-1:0] chan_t;

  // Unsigned sum of all sources on one side
  typedef logic [`SND_MIX_W-1:0] mix_t;

  // Final unsigned sample
  typedef logic [`SND_PCM_W-1:0] pcm_t;

endpackage

// ==== hw/snd_regs.sv ====
`timescale 1ns/1ps
`include "snd_consts.svh"

module snd_regs (
  input  logic           fclk,
  input  logic           rst,
  input  logic           io_wr,
  input  logic [7:0]     io_addr,
  input  snd_pkg::chan_t io_data,
  output snd_pkg::chan_t covox_a,
  output snd_pkg::chan_t covox_b,
  output snd_pkg::chan_t covox_c,
  output snd_pkg::chan_t covox_d,
  output logic           beeper
);

  import snd_pkg::*;

  // Soundrive channels, A..D in index order
  chan_t      chan_q [4];
  logic [1:0] chan_sel;
  logic       chan_hit;
  logic       beep_hit;

  // Full 8-bit match on the covox ports
  always_comb begin
    chan_hit = 1'b1;
    chan_sel = 2'd0;
    case (io_addr)
      `SND_PORT_A: chan_sel = 2'd0;
      `SND_PORT_B: chan_sel = 2'd1;
      `SND_PORT_C: chan_sel = 2'd2;
      `SND_PORT_D: chan_sel = 2'd3;
      default: chan_hit = 1'b0;
    endcase
  end

  // Port #FE is any even address
  assign beep_hit = ~io_addr[0];

  always_ff @(posedge fclk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        chan_q[i] <= '0;
      end
    end else if (io_wr && chan_hit) begin
      chan_q[chan_sel] <= io_data;
    end
  end

  // Covox ports are odd, so they never reach this bit
  always_ff @(posedge fclk) begin
    if (rst) begin
      beeper <= 1'b0;
    end else if (io_wr && beep_hit) begin
      beeper <= io_data[`SND_BEEPER_BIT];
    end
  end

  assign covox_a = chan_q[0];
  assign covox_b = chan_q[1];
  assign covox_c = chan_q[2];
  assign covox_d = chan_q[3];

endmodule

// ==== hw/sample_tick.sv ====
`timescale 1ns/1ps
`include "snd_consts.svh"

module sample_tick #(
  parameter int DIV = `SND_SAMPLE_DIV
) (
  input  logic fclk,
  input  logic rst,
  output logic tick
);

  localparam int CW = $clog2(DIV);

  logic [CW-1:0] cnt;
  logic          wrap;

  assign wrap = (cnt == CW'(DIV - 1));

  // Free-running period counter
  always_ff @(posedge fclk) begin
    if (rst) begin
      cnt <= '0;
    end else if (wrap) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // One pulse per period, DIV cycles after reset
  always_ff @(posedge fclk) begin
    if (rst) begin
      tick <= 1'b0;
    end else begin
      tick <= wrap;
    end
  end

endmodule

// ==== hw/audio_mixer.sv ====
`timescale 1ns/1ps
`include "snd_consts.svh"

module audio_mixer (
  input  logic           fclk,
  input  logic           rst,
  input  logic           tick,
  input  snd_pkg::chan_t covox_a,
  input  snd_pkg::chan_t covox_b,
  input  snd_pkg::chan_t covox_c,
  input  snd_pkg::chan_t covox_d,
  input  logic           beeper,
  output snd_pkg::mix_t  mix_l,
  output snd_pkg::mix_t  mix_r,
  output logic           mix_valid
);

  import snd_pkg::*;

  mix_t beep_term;
  mix_t sum_l;
  mix_t sum_r;

  // Covox channel weighted by 4, zero extended to the mix width
  function automatic mix_t weigh(input chan_t chan);
    return mix_t'({chan, 2'b00});
  endfunction

  // Beeper is shared by both sides
  assign beep_term = beeper ? mix_t'(`SND_BEEP_LEVEL) : '0;

  // Largest sum is 2296, no overflow in 12 bits
  assign sum_l = weigh(covox_a) + weigh(covox_b) + beep_term;
  assign sum_r = weigh(covox_c) + weigh(covox_d) + beep_term;

  // Sample the sources once per period
  always_ff @(posedge fclk) begin
    if (tick) begin
      mix_l <= sum_l;
      mix_r <= sum_r;
    end
  end

  always_ff @(posedge fclk) begin
    if (rst) begin
      mix_valid <= 1'b0;
    end else begin
      mix_valid <= tick;
    end
  end

endmodule

// ==== hw/snd_compressor.sv ====
`timescale 1ns/1ps
`include "snd_consts.svh"

module snd_compressor (
  input  logic          fclk,
  input  logic          rst,
  input  logic          mix_valid,
  input  snd_pkg::mix_t mix,
  output snd_pkg::pcm_t pcm
);

  import snd_pkg::*;

  localparam int SHIFT = `SND_PCM_W - `SND_MIX_W;

  mix_t over;
  mix_t level;
  logic above;

  assign above = (mix > mix_t'(`SND_KNEE));

  // Only meaningful when above the knee
  assign over = mix - mix_t'(`SND_KNEE);

  // Half slope past the knee, truncating
  assign level = above ? mix_t'(`SND_KNEE) + (over >> 1) : mix;

  // Scale by 16 to full PCM range
  always_ff @(posedge fclk) begin
    if (rst) begin
      pcm <= '0;
    end else if (mix_valid) begin
      pcm <= pcm_t'(level) << SHIFT;
    end
  end

endmodule

// ==== hw/snd_top.sv ====
`timescale 1ns/1ps
`include "snd_consts.svh"

module snd_top (
  input  logic           fclk,
  input  logic           rst,
  input  logic           io_wr,
  input  logic [7:0]     io_addr,
  input  snd_pkg::chan_t io_data,
  output snd_pkg::pcm_t  sound_l,
  output snd_pkg::pcm_t  sound_r
);

  import snd_pkg::*;

  chan_t covox_a;
  chan_t covox_b;
  chan_t covox_c;
  chan_t covox_d;
  logic  beeper;
  logic  tick;
  mix_t  mix_l;
  mix_t  mix_r;
  logic  mix_valid;

  // Port decode and Soundrive registers
  snd_regs i_regs (
    .fclk    (fclk),
    .rst     (rst),
    .io_wr   (io_wr),
    .io_addr (io_addr),
    .io_data (io_data),
    .covox_a (covox_a),
    .covox_b (covox_b),
    .covox_c (covox_c),
    .covox_d (covox_d),
    .beeper  (beeper)
  );

  sample_tick #(
    .DIV (`SND_SAMPLE_DIV)
  ) i_tick (
    .fclk (fclk),
    .rst  (rst),
    .tick (tick)
  );

  audio_mixer i_mixer (
    .fclk      (fclk),
    .rst       (rst),
    .tick      (tick),
    .covox_a   (covox_a),
    .covox_b   (covox_b),
    .covox_c   (covox_c),
    .covox_d   (covox_d),
    .beeper    (beeper),
    .mix_l     (mix_l),
    .mix_r     (mix_r),
    .mix_valid (mix_valid)
  );

  // One compressor per side
  snd_compressor i_comp_l (
    .fclk      (fclk),
    .rst       (rst),
    .mix_valid (mix_valid),
    .mix       (mix_l),
    .pcm       (sound_l)
  );

  snd_compressor i_comp_r (
    .fclk      (fclk),
    .rst       (rst),
    .mix_valid (mix_valid),
    .mix       (mix_r),
    .pcm       (sound_r)
  );

endmodule

// ==== verification/snd_asserts.sv ====
`timescale 1ns/1ps

module snd_asserts (
  input logic          fclk,
  input logic          rst,
  input logic          tick,
  input logic          mix_valid,
  input snd_pkg::pcm_t sound_l
);

  // Single-cycle sample enable
  tick_single: assert property (
    @(posedge fclk) disable iff (rst)
    tick |=> !tick
  ) else $error("tick high in two consecutive cycles");

  // Mixer output is registered on tick
  valid_after_tick: assert property (
    @(posedge fclk) disable iff (rst)
    mix_valid == $past(tick)
  ) else $error("mix_valid does not follow tick by one cycle");

  // Compressor output moves only on a valid mix
  sound_l_on_valid: assert property (
    @(posedge fclk) disable iff (rst)
    !$stable(sound_l) |-> $past(mix_valid)
  ) else $error("sound_l changed without a preceding mix_valid");

endmodule

bind snd_top snd_asserts i_asserts (
  .fclk      (fclk),
  .rst       (rst),
  .tick      (tick),
  .mix_valid (mix_valid),
  .sound_l   (sound_l)
);

// ==== verification/tb_snd.sv ====
`timescale 1ns/1ps
`include "snd_consts.svh"

module tb_snd;

  localparam logic [31:0] SEED = 32'h6019;
  localparam int TIMEOUT_CYCLES = 40;
  localparam int SETTLE_CYCLES = `SND_SAMPLE_DIV + 4;
  localparam int BURST_WRITES = 300;

  logic        fclk;
  logic        rst;
  logic        io_wr;
  logic [7:0]  io_addr;
  logic [7:0]  io_data;
  logic [15:0] sound_l;
  logic [15:0] sound_r;

  logic [31:0] rand_state;
  int          mdl_chan [4];
  int          mdl_beep;
  int          value_errs;
  int          timeout_errs;

  snd_top i_dut (
    .fclk    (fclk),
    .rst     (rst),
    .io_wr   (io_wr),
    .io_addr (io_addr),
    .io_data (io_data),
    .sound_l (sound_l),
    .sound_r (sound_r)
  );

  always #50 fclk = ~fclk;

  function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [7:0] port_addr(input int idx);
    case (idx)
      0: return `SND_PORT_A;
      1: return `SND_PORT_B;
      2: return `SND_PORT_C;
      default: return `SND_PORT_D;
    endcase
  endfunction

  // Odd address that hits no covox channel
  function automatic logic [7:0] odd_other_addr(input logic [7:0] r);
    logic [7:0] a;
    a = r | 8'h01;
    if (a == `SND_PORT_A || a == `SND_PORT_B || a == `SND_PORT_C || a == `SND_PORT_D) begin
      a = 8'h3F;
    end
    return a;
  endfunction

  function automatic int mix_model(input int x, input int y);
    return 4 * x + 4 * y + `SND_BEEP_LEVEL * mdl_beep;
  endfunction

  function automatic int knee_model(input int m);
    if (m <= `SND_KNEE) begin
      return 16 * m;
    end
    return 16 * (`SND_KNEE + (m - `SND_KNEE) / 2);
  endfunction

  task automatic check_val(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAIL %s expected %0d actual %0d", name, expected, actual);
      value_errs++;
    end
  endtask

  // One bus strobe, model follows the port decode
  task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
    @(posedge fclk);
    io_wr   <= 1'b1;
    io_addr <= addr;
    io_data <= data;
    for (int i = 0; i < 4; i++) begin
      if (addr == port_addr(i)) begin
        mdl_chan[i] = int'(data);
      end
    end
    if (!addr[0]) begin
      mdl_beep = data[`SND_BEEPER_BIT] ? 1 : 0;
    end
  endtask

  task automatic io_idle();
    @(posedge fclk);
    io_wr <= 1'b0;
  endtask

  // Poll until the pipeline has drained and outputs match the model
  task automatic settle_and_check(input string name);
    int n;
    int exp_l;
    int exp_r;
    exp_l = knee_model(mix_model(mdl_chan[0], mdl_chan[1]));
    exp_r = knee_model(mix_model(mdl_chan[2], mdl_chan[3]));
    io_idle();
    n = 0;
    while (n < TIMEOUT_CYCLES &&
           !(n >= SETTLE_CYCLES && int'(sound_l) == exp_l && int'(sound_r) == exp_r)) begin
      @(negedge fclk);
      n++;
    end
    if (n >= TIMEOUT_CYCLES) begin
      $display("ERROR: %s outputs did not reach the expected value within %0d cycles",
               name, TIMEOUT_CYCLES);
      timeout_errs++;
    end
    check_val({name, "_l"}, exp_l, int'(sound_l));
    check_val({name, "_r"}, exp_r, int'(sound_r));
  endtask

  initial begin
    logic [31:0] rnd;
    logic [7:0]  addr;

    fclk = 1'b0;
    rst = 1'b1;
    io_wr = 1'b0;
    io_addr = 8'h00;
    io_data = 8'h00;
    rand_state = SEED;
    mdl_beep = 0;
    value_errs = 0;
    timeout_errs = 0;
    for (int i = 0; i < 4; i++) begin
      mdl_chan[i] = 0;
    end

    repeat (10) @(posedge fclk);
    rst <= 1'b0;
    @(negedge fclk);
    check_val("reset_l", 0, int'(sound_l));
    check_val("reset_r", 0, int'(sound_r));

    // Each covox port on its own, mostly below the knee
    for (int p = 0; p < 4; p++) begin
      for (int k = 0; k < 6; k++) begin
        rnd = lcg_next();
        io_write(port_addr(p), rnd[23:16]);
        settle_and_check("covox_port");
      end
    end

    // All channels high, past the knee
    for (int k = 0; k < 8; k++) begin
      for (int p = 0; p < 4; p++) begin
        rnd = lcg_next();
        io_write(port_addr(p), rnd[23:16] | 8'h80);
      end
      settle_and_check("knee");
    end
    io_write(`SND_PORT_A, 8'd128);
    io_write(`SND_PORT_B, 8'd128);
    io_write(`SND_PORT_C, 8'd128);
    io_write(`SND_PORT_D, 8'd129);
    settle_and_check("knee_edge");

    io_write(8'hFE, 8'h10);
    settle_and_check("beep_on");
    // Beeper bit clear, so a stray beeper decode would show
    rnd = lcg_next();
    io_write(odd_other_addr(rnd[15:8]), rnd[23:16] & 8'hEF);
    settle_and_check("odd_ignored");
    io_write(8'hFE, 8'hEF);
    settle_and_check("beep_off");
    rnd = lcg_next();
    io_write(rnd[15:8] & 8'hFE, 8'h10);
    settle_and_check("beep_even");
    io_write(`SND_PORT_D, 8'hFF);
    io_write(`SND_PORT_C, 8'hFF);
    settle_and_check("beep_full");

    // Dense random traffic, gaps shorter than a sample period
    for (int k = 0; k < BURST_WRITES; k++) begin
      rnd = lcg_next();
      case (rnd[2:0])
        3'd4, 3'd5: addr = rnd[15:8] & 8'hFE;
        3'd6, 3'd7: addr = odd_other_addr(rnd[15:8]);
        default: addr = port_addr(int'(rnd[1:0]));
      endcase
      io_write(addr, rnd[23:16]);
      repeat (int'(rnd[26:24])) io_idle();
    end
    settle_and_check("burst");

    $display("Checks done: %0d value errors, %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+hw
hw/snd_pkg.sv
hw/snd_regs.sv
hw/sample_tick.sv
hw/audio_mixer.sv
hw/snd_compressor.sv
hw/snd_top.sv
verification/snd_asserts.sv
verification/tb_snd.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP      = tb_snd
FILELIST = compile.f

SOURCES  = $(shell grep -v '^+' $(FILELIST)) hw/snd_consts.svh
BIN      = obj_dir/V$(TOP)
PASS_MSG = *** PASSED ***

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf obj_dir
